// File: src/abuf_pkg.sv
/*
  Widths, types and address decode shared by the align buffer
  Lines are 128 bits, requests are byte addresses on halfword boundaries
  Address bit 0 is ignored everywhere
*/
package abuf_pkg;

  // ==================================================
  // Widths
  // ==================================================
  localparam int XLEN          = 32;
  localparam int BLK_BITS      = 128;
  localparam int PARCEL_BITS   = 16;
  localparam int WORD_BITS     = 32;
  localparam int WORDS_PER_BLK = BLK_BITS / WORD_BITS;
  localparam int OFFSET_BITS   = $clog2(BLK_BITS / 8);
  localparam int LINE_BITS     = XLEN - OFFSET_BITS;
  localparam int WSEL_BITS     = $clog2(WORDS_PER_BLK);

  // ==================================================
  // Types
  // ==================================================
  typedef logic [PARCEL_BITS-1:0] parcel_t;
  typedef logic [WORD_BITS-1:0] instr_t;
  // Word 0 sits in the low bits, as it does in memory
  typedef logic [WORDS_PER_BLK-1:0][WORD_BITS-1:0] blk_t;
  typedef logic [XLEN-1:0] addr_t;
  typedef logic [LINE_BITS-1:0] line_t;
  typedef logic [WSEL_BITS-1:0] wsel_t;

  // ==================================================
  // Address decode
  // ==================================================
  // Line number, offset bits dropped
  function automatic line_t line_of(input addr_t addr);
    return addr[XLEN-1:OFFSET_BITS];
  endfunction

  // Word within the line
  function automatic wsel_t word_sel_of(input addr_t addr);
    return addr[OFFSET_BITS-1:2];
  endfunction

  // Upper halfword of a word
  function automatic logic half_sel_of(input addr_t addr);
    return addr[1];
  endfunction

  // Last halfword of the line, offset 14
  function automatic logic crosses_line(input addr_t addr);
    return &addr[OFFSET_BITS-1:1];
  endfunction

  // Line holding the upper parcel; wraps at the top of the address space
  function automatic line_t second_line_of(input addr_t addr);
    return line_of(addr) + LINE_BITS'(crosses_line(addr));
  endfunction

endpackage

// File: src/abuf_fill_if.sv
/*
  Line refill bus from the miss sequencer to the tag store and banks
  wr_en is a single-cycle pulse; receivers write in that cycle
*/
`timescale 1ns/1ns

interface abuf_fill_if
  import abuf_pkg::*;
();

  // Write strobe, one cycle per refill
  logic  wr_en;
  // Full line number, receivers pick index and tag from it
  line_t wr_line;
  // Whole line as returned by memory
  blk_t  wr_blk;

  // Sequencer side
  modport driver (
    output wr_en,
    output wr_line,
    output wr_blk
  );

  // Tag store and parcel banks
  modport receiver (
    input wr_en,
    input wr_line,
    input wr_blk
  );

endinterface

// File: src/abuf_tag_store.sv
/*
  Direct-mapped tag array, one valid bit and one tag per set
  Looks up the first and second line of a request combinationally
  NUM_SETS must be a power of two, at least 2
  Reset and flush clear all valid bits; tags themselves are not cleared
*/
`timescale 1ns/1ns

module abuf_tag_store
  import abuf_pkg::*;
#(
  parameter int NUM_SETS = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 flush_i,
  input  logic                 req_valid_i,
  input  addr_t                req_addr_i,
  abuf_fill_if.receiver        fill_rx,
  output logic                 hit_first_o,
  output logic                 hit_second_o
);

  localparam int IDX_BITS = $clog2(NUM_SETS);
  localparam int TAG_BITS = LINE_BITS - IDX_BITS;

  // ==================================================
  // Storage
  // ==================================================
  logic [NUM_SETS-1:0] valid_q;
  logic [TAG_BITS-1:0] tag_q [NUM_SETS];

  // ==================================================
  // Lookup of both lines
  // ==================================================
  line_t               first_line;
  line_t               second_line;
  logic [IDX_BITS-1:0] first_idx;
  logic [IDX_BITS-1:0] second_idx;
  logic [TAG_BITS-1:0] first_tag;
  logic [TAG_BITS-1:0] second_tag;

  assign first_line  = line_of(req_addr_i);
  // Same as the first line unless the request crosses
  assign second_line = second_line_of(req_addr_i);

  assign first_idx   = first_line[IDX_BITS-1:0];
  assign first_tag   = first_line[LINE_BITS-1:IDX_BITS];
  assign second_idx  = second_line[IDX_BITS-1:0];
  assign second_tag  = second_line[LINE_BITS-1:IDX_BITS];

  // Hit needs a live request, a valid set and a matching tag
  assign hit_first_o  = req_valid_i && valid_q[first_idx] && (tag_q[first_idx] == first_tag);
  assign hit_second_o = req_valid_i && valid_q[second_idx] &&
                        (tag_q[second_idx] == second_tag);

  // ==================================================
  // Refill
  // ==================================================
  logic [IDX_BITS-1:0] fill_idx;
  logic [TAG_BITS-1:0] fill_tag;

  assign fill_idx = fill_rx.wr_line[IDX_BITS-1:0];
  assign fill_tag = fill_rx.wr_line[LINE_BITS-1:IDX_BITS];

  // Valid bits, cleared on reset or flush
  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      valid_q <= '0;
    end else if (fill_rx.wr_en) begin
      valid_q[fill_idx] <= 1'b1;
    end
  end

  // Tag written alongside the valid bit
  always_ff @(posedge clk_i) begin
    if (fill_rx.wr_en) begin
      tag_q[fill_idx] <= fill_tag;
    end
  end

endmodule

// File: src/abuf_parcel_bank.sv
/*
  One halfword bank, HALF 0 holds low parcels, HALF 1 high parcels
  A refill writes all four words of the line into the set of wr_line
  Read is combinational; the even bank follows the second line on a crossing
*/
`timescale 1ns/1ns

module abuf_parcel_bank
  import abuf_pkg::*;
#(
  parameter int NUM_SETS = 8,
  parameter int HALF     = 0
) (
  input  logic                          clk_i,
  input  addr_t                         req_addr_i,
  abuf_fill_if.receiver                 fill_rx,
  output parcel_t [WORDS_PER_BLK-1:0]   parcels_o
);

  localparam int IDX_BITS = $clog2(NUM_SETS);

  // One parcel per word per set
  parcel_t mem_q [NUM_SETS][WORDS_PER_BLK];

  line_t               rd_line;
  logic [IDX_BITS-1:0] rd_idx;
  logic [IDX_BITS-1:0] wr_idx;

  // ==================================================
  // Set selection
  // ==================================================
  // Even bank supplies the upper parcel of a crossing fetch, so it
  // reads from the next line; odd bank always reads the first line
  assign rd_line = (HALF == 0) ? second_line_of(req_addr_i) : line_of(req_addr_i);
  assign rd_idx  = rd_line[IDX_BITS-1:0];
  assign wr_idx  = fill_rx.wr_line[IDX_BITS-1:0];

  // ==================================================
  // Per-word write and read
  // ==================================================
  // Pick this bank's halfword out of every word of the line
  always_ff @(posedge clk_i) begin
    if (fill_rx.wr_en) begin
      for (int w = 0; w < WORDS_PER_BLK; w++) begin
        mem_q[wr_idx][w] <= fill_rx.wr_blk[w][HALF*PARCEL_BITS +: PARCEL_BITS];
      end
    end
  end

  for (genvar w = 0; w < WORDS_PER_BLK; w++) begin : gen_word
    assign parcels_o[w] = mem_q[rd_idx][w];
  end

endmodule

// File: src/abuf_miss_sequencer.sv
/*
  Refill FSM, one line request in flight at a time
  A double miss is served as two passes, first line then second line
  A flush during a pending refill keeps the memory request up until its
  response arrives, then drops that response without writing it
*/
`timescale 1ns/1ns

module abuf_miss_sequencer
  import abuf_pkg::*;
#(
  parameter int NUM_SETS = 8
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          flush_i,
  input  logic          req_valid_i,
  input  addr_t         req_addr_i,
  input  logic          hit_first_i,
  input  logic          hit_second_i,
  input  logic          mem_rsp_valid_i,
  input  blk_t          mem_rsp_blk_i,
  output logic          mem_req_valid_o,
  output addr_t         mem_req_addr_o,
  abuf_fill_if.driver   fill_tx
);

  // Adjacent lines must land in different sets, else the two passes
  // of a double miss evict each other forever
  if (NUM_SETS < 2 || (NUM_SETS & (NUM_SETS - 1)) != 0) begin : gen_bad_sets
    $error("NUM_SETS must be a power of two, at least 2");
  end

  typedef enum logic {
    LOOKUP,
    WAIT_MEM
  } state_e;

  state_e state_q;
  logic   mem_req_valid_q;
  logic   drop_q;
  line_t  req_line_q;
  logic   miss;
  logic   issue;
  line_t  miss_line;

  // ==================================================
  // Miss decode
  // ==================================================
  assign miss      = req_valid_i && !(hit_first_i && hit_second_i);
  // First line has priority, second line only once the first is present
  assign miss_line = hit_first_i ? second_line_of(req_addr_i) : line_of(req_addr_i);
  // No new request while a dropped one is still outstanding
  assign issue     = (state_q == LOOKUP) && !drop_q && !flush_i && miss;

  // ==================================================
  // State and request valid
  // ==================================================
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q         <= LOOKUP;
      mem_req_valid_q <= 1'b0;
      drop_q          <= 1'b0;
    end else if (flush_i) begin
      state_q         <= LOOKUP;
      // Outstanding request stays up until memory answers it
      mem_req_valid_q <= mem_req_valid_q && !mem_rsp_valid_i;
      drop_q          <= mem_req_valid_q && !mem_rsp_valid_i;
    end else begin
      case (state_q)
        LOOKUP: begin
          if (drop_q) begin
            // Stale response retires the old request
            if (mem_rsp_valid_i) begin
              mem_req_valid_q <= 1'b0;
              drop_q          <= 1'b0;
            end
          end else if (issue) begin
            mem_req_valid_q <= 1'b1;
            state_q         <= WAIT_MEM;
          end
        end
        WAIT_MEM: begin
          if (mem_rsp_valid_i) begin
            mem_req_valid_q <= 1'b0;
            state_q         <= LOOKUP;
          end
        end
        default: state_q <= LOOKUP;
      endcase
    end
  end

  // Requested line, held for the fill even if the request address moves
  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_line_q <= miss_line;
    end
  end

  assign mem_req_valid_o = mem_req_valid_q;
  assign mem_req_addr_o  = {req_line_q, {OFFSET_BITS{1'b0}}};

  // ==================================================
  // Refill pulse, in the response cycle
  // ==================================================
  assign fill_tx.wr_en   = (state_q == WAIT_MEM) && mem_rsp_valid_i && !flush_i;
  assign fill_tx.wr_line = req_line_q;
  assign fill_tx.wr_blk  = mem_rsp_blk_i;

endmodule

// File: src/abuf_instr_assemble.sv
/*
  Forms the 32-bit instruction from the even and odd bank parcels
  Purely combinational; valid only when both lines hit
*/
`timescale 1ns/1ns

module abuf_instr_assemble
  import abuf_pkg::*;
(
  input  logic                          req_valid_i,
  input  addr_t                         req_addr_i,
  input  logic                          hit_first_i,
  input  logic                          hit_second_i,
  input  parcel_t [WORDS_PER_BLK-1:0]   even_parcels_i,
  input  parcel_t [WORDS_PER_BLK-1:0]   odd_parcels_i,
  output logic                          rsp_valid_o,
  output instr_t                        rsp_instr_o
);

  wsel_t   word_sel;
  wsel_t   next_word;
  logic    half_sel;
  parcel_t lo_parcel;
  parcel_t hi_parcel;

  assign word_sel  = word_sel_of(req_addr_i);
  assign half_sel  = half_sel_of(req_addr_i);
  // Wraps to word 0 at offset 14
  assign next_word = word_sel + wsel_t'(1);

  // ==================================================
  // Parcel select
  // ==================================================
  // Word aligned   {odd[w], even[w]}
  // Halfword       {even[w+1], odd[w]}
  // Line crossing  {even[0] of next line, odd[3]}
  always_comb begin
    if (!half_sel) begin
      lo_parcel = even_parcels_i[word_sel];
      hi_parcel = odd_parcels_i[word_sel];
    end else begin
      lo_parcel = odd_parcels_i[word_sel];
      // Even bank already indexes the next line when word 3 wraps to 0
      hi_parcel = even_parcels_i[next_word];
    end
  end

  assign rsp_instr_o = {hi_parcel, lo_parcel};
  assign rsp_valid_o = req_valid_i && hit_first_i && hit_second_i;

endmodule

// File: src/align_buffer_top.sv
/*
  Instruction align buffer, direct-mapped with split even/odd parcel banks
  Requester holds req_valid_i and req_addr_i until rsp_valid_o
  Memory returns one whole line per request; addresses are line aligned
  NUM_SETS must be a power of two, at least 2
*/
`timescale 1ns/1ns

module align_buffer_top
  import abuf_pkg::*;
#(
  parameter int NUM_SETS = 8
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   flush_i,
  // Fetch side
  input  logic   req_valid_i,
  input  addr_t  req_addr_i,
  output logic   rsp_valid_o,
  output instr_t rsp_instr_o,
  // Lower memory side
  output logic   mem_req_valid_o,
  output addr_t  mem_req_addr_o,
  input  logic   mem_rsp_valid_i,
  input  blk_t   mem_rsp_blk_i
);

  // ==================================================
  // Internal wiring
  // ==================================================
  logic                         hit_first;
  logic                         hit_second;
  parcel_t [WORDS_PER_BLK-1:0]  even_parcels;
  parcel_t [WORDS_PER_BLK-1:0]  odd_parcels;

  // Refill bus shared by tag store and both banks
  abuf_fill_if fill_bus ();

  abuf_tag_store #(
    .NUM_SETS (NUM_SETS)
  ) tag_store_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (flush_i),
    .req_valid_i  (req_valid_i),
    .req_addr_i   (req_addr_i),
    .fill_rx      (fill_bus.receiver),
    .hit_first_o  (hit_first),
    .hit_second_o (hit_second)
  );

  // Low halfword of each word
  abuf_parcel_bank #(
    .NUM_SETS (NUM_SETS),
    .HALF     (0)
  ) even_bank_i (
    .clk_i      (clk_i),
    .req_addr_i (req_addr_i),
    .fill_rx    (fill_bus.receiver),
    .parcels_o  (even_parcels)
  );

  // High halfword of each word
  abuf_parcel_bank #(
    .NUM_SETS (NUM_SETS),
    .HALF     (1)
  ) odd_bank_i (
    .clk_i      (clk_i),
    .req_addr_i (req_addr_i),
    .fill_rx    (fill_bus.receiver),
    .parcels_o  (odd_parcels)
  );

  abuf_miss_sequencer #(
    .NUM_SETS (NUM_SETS)
  ) miss_sequencer_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .hit_first_i     (hit_first),
    .hit_second_i    (hit_second),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_blk_i   (mem_rsp_blk_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .fill_tx         (fill_bus.driver)
  );

  abuf_instr_assemble instr_assemble_i (
    .req_valid_i    (req_valid_i),
    .req_addr_i     (req_addr_i),
    .hit_first_i    (hit_first),
    .hit_second_i   (hit_second),
    .even_parcels_i (even_parcels),
    .odd_parcels_i  (odd_parcels),
    .rsp_valid_o    (rsp_valid_o),
    .rsp_instr_o    (rsp_instr_o)
  );

endmodule

// File: verif/align_buffer_checker.sv
/*
  Concurrent checks on the align buffer top level, bound to align_buffer_top
  Memory content follows the testbench model: halfword at a is a[16:1] ^ 16'h5a3c
  Failures are counted in fail_count, which the testbench reads at the end
*/
`timescale 1ns/1ns

module align_buffer_checker
  import abuf_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_i,
  input  addr_t  req_addr_i,
  input  logic   rsp_valid_i,
  input  instr_t rsp_instr_i,
  input  logic   mem_req_valid_i,
  input  addr_t  mem_req_addr_i,
  input  logic   mem_rsp_valid_i
);

  int unsigned fail_count = 0;

  // Reference content of the memory model
  function automatic parcel_t model_halfword(input addr_t a);
    return a[16:1] ^ 16'h5a3c;
  endfunction

  // Upper parcel comes from the next halfword address
  function automatic instr_t model_instr(input addr_t a);
    return {model_halfword(a + 32'd2), model_halfword(a)};
  endfunction

  // ==================================================
  // Response data
  // ==================================================
  rsp_data_ok: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |-> (rsp_instr_i == model_instr(req_addr_i)))
  else begin
    fail_count++;
    $error("Response data does not match memory content at %h", req_addr_i);
  end

  // ==================================================
  // Memory request protocol
  // ==================================================
  // Held with the same address until the response cycle
  mem_req_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (mem_req_valid_i && !mem_rsp_valid_i) |=> (mem_req_valid_i && $stable(mem_req_addr_i)))
  else begin
    fail_count++;
    $error("Memory request dropped or changed before its response");
  end

  mem_req_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    mem_req_valid_i |-> (mem_req_addr_i[OFFSET_BITS-1:0] == '0))
  else begin
    fail_count++;
    $error("Memory request address %h is not line aligned", mem_req_addr_i);
  end

  // Checked one cycle into reset, once the registers have seen it
  mem_req_reset: assert property (@(posedge clk_i)
    $past(rst_i) |-> !mem_req_valid_i)
  else begin
    fail_count++;
    $error("Memory request valid high during reset");
  end

endmodule

bind align_buffer_top align_buffer_checker checker_i (
  .clk_i           (clk_i),
  .rst_i           (rst_i),
  .req_addr_i      (req_addr_i),
  .rsp_valid_i     (rsp_valid_o),
  .rsp_instr_i     (rsp_instr_o),
  .mem_req_valid_i (mem_req_valid_o),
  .mem_req_addr_i  (mem_req_addr_o),
  .mem_rsp_valid_i (mem_rsp_valid_i)
);

// File: verif/align_buffer_tb.sv
/*
  Testbench for the align buffer with a line memory model of 1 to 4 cycles latency
  Memory halfword at byte a is a[16:1] ^ 16'h5a3c, so data is unique below 128 KB
  Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge
*/
`timescale 1ns/1ns

module align_buffer_tb
  import abuf_pkg::*;
();

  localparam int MAX_FETCHES      = 60;
  localparam int CYCLES_PER_FETCH = 50;
  localparam int TIMEOUT_CYCLES   = MAX_FETCHES * CYCLES_PER_FETCH;
  localparam int RANDOM_FETCHES   = 40;

  logic   clk_i = 1'b0;
  logic   rst_i;
  logic   flush_i;
  logic   req_valid_i;
  addr_t  req_addr_i;
  logic   rsp_valid_o;
  instr_t rsp_instr_o;
  logic   mem_req_valid_o;
  addr_t  mem_req_addr_o;
  logic   mem_rsp_valid_i;
  blk_t   mem_rsp_blk_i;

  int          errors = 0;
  int          cycle_count = 0;
  int          req_count = 0;
  addr_t       req_log [$];
  logic        mem_busy;
  int          mem_wait;
  addr_t       mem_addr;
  logic [31:0] lat_state = 32'hb6f3;
  logic [31:0] addr_state = 32'hb6f3;

  align_buffer_top #(
    .NUM_SETS (8)
  ) align_buffer_top_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .flush_i         (flush_i),
    .req_valid_i     (req_valid_i),
    .req_addr_i      (req_addr_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_instr_o     (rsp_instr_o),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_blk_i   (mem_rsp_blk_i)
  );

  always #4 clk_i = ~clk_i;

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic parcel_t halfword_at(input addr_t a);
    return a[16:1] ^ 16'h5a3c;
  endfunction

  function automatic instr_t expected_instr(input addr_t a);
    return {halfword_at(a + 32'd2), halfword_at(a)};
  endfunction

  // Word w of the line holds the halfwords at base+4w and base+4w+2
  function automatic blk_t line_data(input addr_t base);
    blk_t blk;
    for (int w = 0; w < WORDS_PER_BLK; w++) begin
      blk[w] = {halfword_at(base + 32'(4 * w) + 32'd2), halfword_at(base + 32'(4 * w))};
    end
    return blk;
  endfunction

  // ==================================================
  // Memory model, one request at a time
  // ==================================================
  initial begin : memory_model
    mem_rsp_valid_i = 1'b0;
    mem_rsp_blk_i   = '0;
    mem_busy        = 1'b0;
    mem_wait        = 0;
    mem_addr        = '0;
    forever begin
      @(posedge clk_i);
      #1;
      if (rst_i) begin
        mem_rsp_valid_i = 1'b0;
        mem_busy        = 1'b0;
      end else if (mem_rsp_valid_i) begin
        // Response lasts one cycle, the request has been retired
        mem_rsp_valid_i = 1'b0;
        mem_busy        = 1'b0;
      end else if (mem_busy) begin
        if (mem_wait == 0) begin
          mem_rsp_valid_i = 1'b1;
          mem_rsp_blk_i   = line_data(mem_addr);
        end else begin
          mem_wait--;
        end
      end else if (mem_req_valid_o) begin
        mem_busy  = 1'b1;
        mem_addr  = mem_req_addr_o;
        lat_state = lcg_next(lat_state);
        // 0 to 3 extra cycles, response 1 to 4 cycles after the request
        mem_wait  = int'(lat_state[17:16]);
        req_count++;
        req_log.push_back(mem_req_addr_o);
      end
    end
  end

  // ==================================================
  // Timeout
  // ==================================================
  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, the run did not finish", cycle_count);
      $display("Errors: %0d testbench, %0d assertion", errors,
               align_buffer_top_i.checker_i.fail_count);
      $display("Test failed");
      $finish;
    end
  end

  // ==================================================
  // Stimulus helpers, called 1 ns after a rising edge
  // ==================================================
  task automatic fetch_and_check(input string name, input addr_t addr,
                                 output int lat, output int reqs);
    int     first_req;
    logic   got;
    instr_t actual;
    first_req   = req_count;
    got         = 1'b0;
    actual      = '0;
    lat         = 0;
    req_valid_i = 1'b1;
    req_addr_i  = addr;
    while (!got && lat < CYCLES_PER_FETCH) begin
      @(negedge clk_i);
      if (rsp_valid_o) begin
        got    = 1'b1;
        actual = rsp_instr_o;
      end else begin
        lat++;
      end
    end
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    reqs        = req_count - first_req;
    if (!got) begin
      errors++;
      $display("%s: no response for address %h within %0d cycles", name, addr, lat);
    end else if (actual !== expected_instr(addr)) begin
      errors++;
      $display("MISMATCH %s: expected %h, actual %h", name, expected_instr(addr), actual);
    end
  endtask

  task automatic expect_requests(input string name, input int expected, input int actual);
    if (expected == 0 && actual != 0) begin
      errors++;
      $display("%s: unexpected memory request on a cached address", name);
    end else if (actual != expected) begin
      errors++;
      $display("MISMATCH %s requests: expected %0d, actual %0d", name, expected, actual);
    end
  endtask

  task automatic expect_request_addr(input string name, input int idx, input addr_t expected);
    if (req_log.size() <= idx) begin
      errors++;
      $display("%s: memory request %0d was never issued", name, idx);
    end else if (req_log[idx] !== expected) begin
      errors++;
      $display("MISMATCH %s request %0d: expected %h, actual %h", name, idx, expected,
               req_log[idx]);
    end
  endtask

  task automatic expect_same_cycle(input string name, input int lat);
    if (lat != 0) begin
      errors++;
      $display("%s: cached fetch answered after %0d cycles, not in the request cycle",
               name, lat);
    end
  endtask

  task automatic pulse_flush();
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin : main
    int    lat;
    int    reqs;
    addr_t addr;
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    req_valid_i = 1'b0;
    req_addr_i  = '0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // Cold word-aligned fetch, one line
    req_log.delete();
    fetch_and_check("cold_aligned", 32'h0000_0040, lat, reqs);
    expect_requests("cold_aligned", 1, reqs);
    expect_request_addr("cold_aligned", 0, 32'h0000_0040);

    // Halfword offset inside a line
    req_log.delete();
    fetch_and_check("half_offset", 32'h0000_0086, lat, reqs);
    expect_requests("half_offset", 1, reqs);
    expect_request_addr("half_offset", 0, 32'h0000_0080);

    // Offset 14, both lines cold, own line first
    req_log.delete();
    fetch_and_check("cross_cold", 32'h0000_00ce, lat, reqs);
    expect_requests("cross_cold", 2, reqs);
    expect_request_addr("cross_cold", 0, 32'h0000_00c0);
    expect_request_addr("cross_cold", 1, 32'h0000_00d0);

    // Cached addresses answer in the request cycle
    fetch_and_check("hit_cross", 32'h0000_00ce, lat, reqs);
    expect_requests("hit_cross", 0, reqs);
    expect_same_cycle("hit_cross", lat);
    fetch_and_check("hit_half", 32'h0000_0086, lat, reqs);
    expect_requests("hit_half", 0, reqs);
    expect_same_cycle("hit_half", lat);

    // Flush forgets every line
    pulse_flush();
    req_log.delete();
    fetch_and_check("flush_cross", 32'h0000_00ce, lat, reqs);
    expect_requests("flush_cross", 2, reqs);
    expect_request_addr("flush_cross", 0, 32'h0000_00c0);
    fetch_and_check("flush_half", 32'h0000_0086, lat, reqs);
    expect_requests("flush_half", 1, reqs);

    // Random halfword addresses within 512 bytes, so lines alias and reuse
    for (int i = 0; i < RANDOM_FETCHES; i++) begin
      addr_state = lcg_next(addr_state);
      addr       = {23'd0, addr_state[24:17], 1'b0};
      fetch_and_check("random", addr, lat, reqs);
    end

    repeat (2) @(posedge clk_i);
    $display("Errors: %0d testbench, %0d assertion", errors,
             align_buffer_top_i.checker_i.fail_count);
    if (errors == 0 && align_buffer_top_i.checker_i.fail_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: compile.f
src/abuf_pkg.sv
src/abuf_fill_if.sv
src/abuf_tag_store.sv
src/abuf_parcel_bank.sv
src/abuf_miss_sequencer.sv
src/abuf_instr_assemble.sv
src/align_buffer_top.sv
verif/align_buffer_checker.sv
verif/align_buffer_tb.sv
